// File: list.f
source/memctl_pkg.sv
source/memctl_cmd_if.sv
source/memctl_burst_ctl.sv
source/memctl_parity.sv
source/memctl_afi_issue.sv
source/memctl_rdata_path.sv
source/memctl_top.sv
dv/memctl_checker.sv
dv/memctl_tb.sv

// File: Bender.yml
package:
  name: memctl

sources:
  - source/memctl_pkg.sv
  - source/memctl_cmd_if.sv
  - source/memctl_burst_ctl.sv
  - source/memctl_parity.sv
  - source/memctl_afi_issue.sv
  - source/memctl_rdata_path.sv
  - source/memctl_top.sv
  - target: simulation
    files:
      - dv/memctl_checker.sv
      - dv/memctl_tb.sv

// File: dv/memctl_tb.sv
// testbench of the QDR SRAM controller, runs a table of host bursts against a behavioural memory
`timescale 1ns/10ps

module memctl_tb;

	localparam int NUM_BYTES  = memctl_pkg::NUM_BYTES;
	localparam int DATA_W     = NUM_BYTES * 8;
	localparam int ENC_W      = NUM_BYTES * 9;
	localparam int DEPTH      = 1 << memctl_pkg::ADDR_W;
	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 10;
	localparam int RD_LAT     = 3;
	localparam int NUM_TESTS  = 12;
	localparam int MAX_WAIT   = 20;

	// one table row is one host burst, optionally preceded by a bit flip in the memory
	typedef struct
	{
		bit                 is_read;
		memctl_pkg::addr_t  addr;
		memctl_pkg::burst_t size;
		bit                 corrupt;
		int                 lane;
		int                 bit_idx;
	} row_t;

	// one read beat the host is still waiting for
	typedef struct
	{
		logic [DATA_W-1:0]    data;
		logic [NUM_BYTES-1:0] err;
		int                   test;
		bit                   last;
	} beat_t;

	logic                 afi_clk;
	logic                 rst_n;
	logic                 avl_ready;
	logic                 avl_write_req;
	logic                 avl_read_req;
	memctl_pkg::addr_t    avl_addr;
	memctl_pkg::burst_t   avl_size;
	logic [DATA_W-1:0]    avl_wdata;
	logic                 avl_rdata_valid;
	logic [DATA_W-1:0]    avl_rdata;
	logic [NUM_BYTES-1:0] parity_error;
	logic                 afi_wps_n;
	logic                 afi_rps_n;
	memctl_pkg::addr_t    afi_addr;
	logic [ENC_W-1:0]     afi_wdata;
	logic                 afi_rdata_valid;
	logic [ENC_W-1:0]     afi_rdata;

	row_t                 tbl [NUM_TESTS];
	logic [DATA_W-1:0]    wdata_tbl [NUM_TESTS][8];
	int                   test_err [NUM_TESTS];
	int                   error_count = 0;
	int                   pass_count = 0;
	int                   fail_count = 0;
	integer               seed = 32'h604b;

	// expected host view of every word, kept from the bursts written so far
	logic [DATA_W-1:0]    exp_data [DEPTH];
	logic [NUM_BYTES-1:0] exp_err [DEPTH];
	beat_t                exp_q [$];

	// memory model storage and its read latency pipe
	logic [ENC_W-1:0]     mem [DEPTH];
	logic [RD_LAT-1:0]    rd_vld_pipe;
	logic [ENC_W-1:0]     rd_data_pipe [RD_LAT];

	initial
	begin
		afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) afi_clk = ~afi_clk;
	end

	memctl_top #(.NUM_BYTES(NUM_BYTES)) dut_i
	(
		.afi_clk         (afi_clk),
		.rst_n           (rst_n),
		.avl_ready       (avl_ready),
		.avl_write_req   (avl_write_req),
		.avl_read_req    (avl_read_req),
		.avl_addr        (avl_addr),
		.avl_size        (avl_size),
		.avl_wdata       (avl_wdata),
		.avl_rdata_valid (avl_rdata_valid),
		.avl_rdata       (avl_rdata),
		.parity_error    (parity_error),
		.afi_wps_n       (afi_wps_n),
		.afi_rps_n       (afi_rps_n),
		.afi_addr        (afi_addr),
		.afi_wdata       (afi_wdata),
		.afi_rdata_valid (afi_rdata_valid),
		.afi_rdata       (afi_rdata)
	);

	bind memctl_top memctl_checker #(.NUM_BYTES(NUM_BYTES)) checker_i
	(
		.afi_clk         (afi_clk),
		.rst_n           (rst_n),
		.avl_ready       (avl_ready),
		.avl_write_req   (avl_write_req),
		.avl_read_req    (avl_read_req),
		.avl_rdata_valid (avl_rdata_valid),
		.parity_error    (parity_error),
		.afi_wps_n       (afi_wps_n),
		.afi_rps_n       (afi_rps_n),
		.afi_rdata_valid (afi_rdata_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// behavioural QDR memory
	////////////////////////////////////////////////////////////////////////////

	// selects are flop outputs, so their value at the edge is the one of the cycle before
	// a write stored at an edge is seen by a read sampled at the same edge
	always @(posedge afi_clk)
	begin
		if (!rst_n)
			rd_vld_pipe = '0;
		else
		begin
			if (!afi_wps_n)
				mem[afi_addr] = afi_wdata;
			for (int s = RD_LAT - 1; s > 0; s--)
				rd_data_pipe[s] = rd_data_pipe[s - 1];
			rd_vld_pipe     = {rd_vld_pipe[RD_LAT-2:0], ~afi_rps_n};
			rd_data_pipe[0] = mem[afi_addr];
		end
		#1;
		afi_rdata_valid = rd_vld_pipe[RD_LAT-1];
		afi_rdata       = rd_data_pipe[RD_LAT-1];
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// every byte sits in a nine bit lane with an even parity bit above it
	function automatic logic [ENC_W-1:0] encode_word(input logic [DATA_W-1:0] data);
		logic [ENC_W-1:0] word;
		for (int b = 0; b < NUM_BYTES; b++)
		begin
			word[b*9 +: 8] = data[b*8 +: 8];
			word[b*9 + 8]  = ^data[b*8 +: 8];
		end
		return word;
	endfunction

	task automatic flag_error(input int t, input string msg);
		$display("Error at %0t: test %0d: %s", $time, t, msg);
		error_count++;
		if (t >= 0)
			test_err[t]++;
	endtask

	task automatic report_test(input int t);
		string kind;
		kind = tbl[t].is_read ? "read" : "write";
		if (test_err[t] == 0)
			pass_count++;
		else
			fail_count++;
		$display("test %0d: %s of %0d beats at 0x%h, %0d errors", t, kind, tbl[t].size,
			tbl[t].addr, test_err[t]);
	endtask

	task automatic load_table();
		tbl[0]  = '{1'b0, 10'h010, 3'd4, 1'b0, 0, 0};
		tbl[1]  = '{1'b1, 10'h010, 3'd4, 1'b0, 0, 0};
		tbl[2]  = '{1'b0, 10'h200, 3'd7, 1'b0, 0, 0};
		tbl[3]  = '{1'b1, 10'h200, 3'd7, 1'b0, 0, 0};
		tbl[4]  = '{1'b0, 10'h055, 3'd1, 1'b0, 0, 0};
		// flip the parity bit of lane 2, the data stays intact
		tbl[5]  = '{1'b1, 10'h055, 3'd1, 1'b1, 2, 8};
		tbl[6]  = '{1'b0, 10'h120, 3'd3, 1'b0, 0, 0};
		// flip data bit 3 of lane 1 in the first beat only
		tbl[7]  = '{1'b1, 10'h120, 3'd3, 1'b1, 1, 3};
		// read still in flight while the next write starts, then read that write back
		tbl[8]  = '{1'b1, 10'h012, 3'd2, 1'b0, 0, 0};
		tbl[9]  = '{1'b0, 10'h300, 3'd5, 1'b0, 0, 0};
		tbl[10] = '{1'b1, 10'h300, 3'd5, 1'b0, 0, 0};
		tbl[11] = '{1'b1, 10'h203, 3'd3, 1'b0, 0, 0};
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			test_err[t] = 0;
			for (int i = 0; i < 8; i++)
				wdata_tbl[t][i] = $random(seed);
		end
	endtask

	task automatic wait_ready(input int t);
		int n;
		n = 0;
		while (!avl_ready && n < MAX_WAIT)
		begin
			@(posedge afi_clk);
			#1;
			n++;
		end
		if (!avl_ready)
		begin
			$display("test %0d: the controller never became ready for a new burst", t);
			error_count++;
			test_err[t]++;
		end
	endtask

	// waits until earlier commands have reached the memory, then flips one stored bit
	task automatic corrupt_word(input int t);
		row_t r;
		r = tbl[t];
		repeat (3) @(posedge afi_clk);
		#1;
		mem[r.addr][r.lane*9 + r.bit_idx] = ~mem[r.addr][r.lane*9 + r.bit_idx];
		exp_err[r.addr][r.lane] = ~exp_err[r.addr][r.lane];
		if (r.bit_idx < 8)
			exp_data[r.addr][r.lane*8 + r.bit_idx] = ~exp_data[r.addr][r.lane*8 + r.bit_idx];
	endtask

	// cycle 0 is the accept cycle, cycle i shows beat i-1 on the memory ports
	task automatic run_burst(input int t);
		row_t              r;
		beat_t             b;
		memctl_pkg::addr_t a;
		r = tbl[t];
		wait_ready(t);
		avl_addr = r.addr;
		avl_size = r.size;
		if (r.is_read)
		begin
			avl_read_req = 1'b1;
			for (int i = 0; i < r.size; i++)
			begin
				a      = r.addr + memctl_pkg::addr_t'(i);
				b.data = exp_data[a];
				b.err  = exp_err[a];
				b.test = t;
				b.last = (i == r.size - 1);
				exp_q.push_back(b);
			end
		end
		else
		begin
			avl_write_req = 1'b1;
			avl_wdata     = wdata_tbl[t][0];
		end
		for (int i = 1; i <= r.size; i++)
		begin
			@(posedge afi_clk);
			#1;
			a = r.addr + memctl_pkg::addr_t'(i - 1);
			assert (afi_addr == a)
			else flag_error(t, $sformatf("memory address 0x%h, expected 0x%h", afi_addr, a));
			if (r.is_read)
			begin
				avl_read_req = 1'b0;
				assert (!afi_rps_n && afi_wps_n)
				else flag_error(t, $sformatf("no read select for beat %0d", i - 1));
			end
			else
			begin
				assert (!afi_wps_n && afi_rps_n)
				else flag_error(t, $sformatf("no write select for beat %0d", i - 1));
				assert (afi_wdata == encode_word(wdata_tbl[t][i - 1]))
				else flag_error(t, $sformatf("memory word 0x%h, expected 0x%h", afi_wdata,
					encode_word(wdata_tbl[t][i - 1])));
				exp_data[a] = wdata_tbl[t][i - 1];
				exp_err[a]  = '0;
				if (i < r.size)
					avl_wdata = wdata_tbl[t][i];
				else
					avl_write_req = 1'b0;
			end
			// low for the rest of the burst, high again once the last beat has issued
			assert (avl_ready == (i == r.size))
			else flag_error(t, $sformatf("avl_ready is %b after beat %0d", avl_ready, i - 1));
		end
		if (!r.is_read)
			report_test(t);
	endtask

	task automatic drain_reads();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < MAX_WAIT)
		begin
			@(posedge afi_clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d read beats never came back from the controller", exp_q.size());
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// read return scoreboard
	////////////////////////////////////////////////////////////////////////////

	// beats come back in issue order, sampled away from the clock edge
	always @(negedge afi_clk)
	begin
		beat_t b;
		if (avl_rdata_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("a read beat came back at %0t with no read outstanding", $time);
				error_count++;
			end
			else
			begin
				b = exp_q.pop_front();
				assert (avl_rdata == b.data)
				else flag_error(b.test, $sformatf("read data 0x%h, expected 0x%h", avl_rdata,
					b.data));
				assert (parity_error == b.err)
				else flag_error(b.test, $sformatf("parity flags %b, expected %b", parity_error,
					b.err));
				if (b.last)
					report_test(b.test);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int total;
		rst_n           = 1'b0;
		avl_write_req   = 1'b0;
		avl_read_req    = 1'b0;
		avl_addr        = '0;
		avl_size        = '0;
		avl_wdata       = '0;
		afi_rdata_valid = 1'b0;
		afi_rdata       = '0;
		load_table();
		repeat (RST_CYCLES) @(posedge afi_clk);
		#1;
		rst_n = 1'b1;
		assert (avl_ready && afi_wps_n && afi_rps_n && !avl_rdata_valid)
		else flag_error(-1, "controller outputs not idle after reset");
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			if (tbl[t].corrupt)
				corrupt_word(t);
			run_burst(t);
		end
		drain_reads();
		repeat (4) @(posedge afi_clk);
		total = error_count + dut_i.checker_i.fail_cnt;
		$display("%0d tests passed, %0d failed, %0d errors, %0d checker failures",
			pass_count, fail_count, error_count, dut_i.checker_i.fail_cnt);
		if (total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// every burst is far shorter than 40 cycles
	initial
	begin
		#((NUM_TESTS * 40 + RST_CYCLES) * CLK_PERIOD);
		$display("watchdog expired, the run did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: dv/memctl_checker.sv
// handshake and reset assertions, bound into the controller top level by the testbench
`timescale 1ns/10ps

module memctl_checker
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES
)
(
	input logic                 afi_clk,
	input logic                 rst_n,
	input logic                 avl_ready,
	input logic                 avl_write_req,
	input logic                 avl_read_req,
	input logic                 avl_rdata_valid,
	input logic [NUM_BYTES-1:0] parity_error,
	input logic                 afi_wps_n,
	input logic                 afi_rps_n,
	input logic                 afi_rdata_valid
);

	// number of failed properties so far
	int fail_cnt = 0;

	////////////////////////////////////////////////////////////////////////////
	// reset
	////////////////////////////////////////////////////////////////////////////

	// while reset is held the memory sees no command and the host an idle controller
	a_reset_idle: assert property (@(posedge afi_clk)
		!rst_n |=> (afi_wps_n && afi_rps_n && avl_ready && !avl_rdata_valid))
	else
	begin
		$error("controller not idle while in reset");
		fail_cnt++;
	end

	////////////////////////////////////////////////////////////////////////////
	// host handshake and read return
	////////////////////////////////////////////////////////////////////////////

	// a new read burst is only ever started while the controller is ready
	a_no_read_when_busy: assert property (@(posedge afi_clk) disable iff (!rst_n)
		!avl_ready |-> !avl_read_req)
	else
	begin
		$error("read request while avl_ready is low");
		fail_cnt++;
	end

	// a write select always follows a host write beat by one cycle
	a_write_follows_beat: assert property (@(posedge afi_clk) disable iff (!rst_n)
		!avl_write_req |=> afi_wps_n)
	else
	begin
		$error("write select without a host write beat");
		fail_cnt++;
	end

	// returned data reaches the host exactly one cycle later
	a_read_latency: assert property (@(posedge afi_clk) disable iff (!rst_n)
		afi_rdata_valid |=> avl_rdata_valid)
	else
	begin
		$error("read beat not passed to the host one cycle after the memory");
		fail_cnt++;
	end

	a_quiet_flags: assert property (@(posedge afi_clk) disable iff (!rst_n)
		!avl_rdata_valid |-> (parity_error == '0))
	else
	begin
		$error("parity flags set without a read beat");
		fail_cnt++;
	end

endmodule

// File: source/memctl_top.sv
// top level of the QDR SRAM controller, joins the host port, the memory port and the internal blocks
`timescale 1ns/10ps

module memctl_top
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES
)
(
	input  logic                   afi_clk,
	input  logic                   rst_n,

	// host side
	output logic                   avl_ready,
	input  logic                   avl_write_req,
	input  logic                   avl_read_req,
	input  memctl_pkg::addr_t      avl_addr,
	input  memctl_pkg::burst_t     avl_size,
	input  logic [NUM_BYTES*8-1:0] avl_wdata,
	output logic                   avl_rdata_valid,
	output logic [NUM_BYTES*8-1:0] avl_rdata,
	output logic [NUM_BYTES-1:0]   parity_error,

	// memory side
	output logic                   afi_wps_n,
	output logic                   afi_rps_n,
	output memctl_pkg::addr_t      afi_addr,
	output logic [NUM_BYTES*9-1:0] afi_wdata,
	input  logic                   afi_rdata_valid,
	input  logic [NUM_BYTES*9-1:0] afi_rdata
);

	// write data with parity lanes, on its way to the issue stage
	logic [NUM_BYTES*9-1:0] wdata_enc;

	// read data and flags straight out of the parity checker
	logic [NUM_BYTES*8-1:0] dec_rdata;
	logic [NUM_BYTES-1:0]   dec_error;

	// per-beat requests from the burst FSM
	memctl_cmd_if #(.NUM_BYTES(NUM_BYTES)) cmd_bus ();

	////////////////////////////////////////////////////////////////////////////
	// command side
	////////////////////////////////////////////////////////////////////////////

	memctl_burst_ctl #(.NUM_BYTES(NUM_BYTES)) burst_ctl_i
	(
		.afi_clk       (afi_clk),
		.rst_n         (rst_n),
		.avl_ready     (avl_ready),
		.avl_write_req (avl_write_req),
		.avl_read_req  (avl_read_req),
		.avl_addr      (avl_addr),
		.avl_size      (avl_size),
		.avl_wdata     (avl_wdata),
		.cmd           (cmd_bus.ctl)
	);

	// encodes the request data and checks the memory data in one block
	memctl_parity
	#(
		.NUM_BYTES (NUM_BYTES),
		.DEC_W     (NUM_BYTES * 8),
		.ENC_W     (NUM_BYTES * 9)
	) parity_i
	(
		.wdata_in     (cmd_bus.wdata),
		.wdata_out    (wdata_enc),
		.rdata_valid  (afi_rdata_valid),
		.rdata_in     (afi_rdata),
		.rdata_out    (dec_rdata),
		.parity_error (dec_error)
	);

	memctl_afi_issue #(.NUM_BYTES(NUM_BYTES)) afi_issue_i
	(
		.afi_clk   (afi_clk),
		.rst_n     (rst_n),
		.cmd       (cmd_bus.issue),
		.wdata_enc (wdata_enc),
		.afi_wps_n (afi_wps_n),
		.afi_rps_n (afi_rps_n),
		.afi_addr  (afi_addr),
		.afi_wdata (afi_wdata)
	);

	////////////////////////////////////////////////////////////////////////////
	// read return side
	////////////////////////////////////////////////////////////////////////////

	memctl_rdata_path #(.NUM_BYTES(NUM_BYTES)) rdata_path_i
	(
		.afi_clk         (afi_clk),
		.rst_n           (rst_n),
		.afi_rdata_valid (afi_rdata_valid),
		.dec_rdata       (dec_rdata),
		.dec_error       (dec_error),
		.avl_rdata_valid (avl_rdata_valid),
		.avl_rdata       (avl_rdata),
		.parity_error    (parity_error)
	);

endmodule

// File: source/memctl_rdata_path.sv
// read return stage, registers decoded read beats and their parity flags for the host
`timescale 1ns/10ps

module memctl_rdata_path
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES
)
(
	input  logic                   afi_clk,
	input  logic                   rst_n,
	input  logic                   afi_rdata_valid,
	input  logic [NUM_BYTES*8-1:0] dec_rdata,
	input  logic [NUM_BYTES-1:0]   dec_error,
	output logic                   avl_rdata_valid,
	output logic [NUM_BYTES*8-1:0] avl_rdata,
	output logic [NUM_BYTES-1:0]   parity_error
);

	////////////////////////////////////////////////////////////////////////////
	// valid strobe and error flags
	////////////////////////////////////////////////////////////////////////////

	// every beat the memory returns appears at the host exactly one cycle later
	// there is no back-pressure, so the stage never holds a beat
	always_ff @(posedge afi_clk)
	begin
		if (!rst_n)
		begin
			avl_rdata_valid <= 1'b0;
			parity_error    <= '0;
		end
		else
		begin
			avl_rdata_valid <= afi_rdata_valid;

			// flags belong to one beat only and must not linger into idle cycles
			if (afi_rdata_valid)
				parity_error <= dec_error;
			else
				parity_error <= '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////////////////////

	// data only changes when a new beat arrives, so the host sees stable data
	// until the next one even though it should sample only with the strobe
	always_ff @(posedge afi_clk)
	begin
		if (afi_rdata_valid)
			avl_rdata <= dec_rdata;
	end

endmodule

// File: source/memctl_afi_issue.sv
// command issue stage, registers every beat request onto the memory side ports
`timescale 1ns/10ps

module memctl_afi_issue
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES
)
(
	input  logic                   afi_clk,
	input  logic                   rst_n,
	memctl_cmd_if.issue            cmd,
	input  logic [NUM_BYTES*9-1:0] wdata_enc,
	output logic                   afi_wps_n,
	output logic                   afi_rps_n,
	output memctl_pkg::addr_t      afi_addr,
	output logic [NUM_BYTES*9-1:0] afi_wdata
);

	////////////////////////////////////////////////////////////////////////////
	// select strobes
	////////////////////////////////////////////////////////////////////////////

	// the selects are active low and must be quiet while in reset
	// a select is low for exactly one cycle per beat, one cycle after the request
	always_ff @(posedge afi_clk)
	begin
		if (!rst_n)
		begin
			afi_wps_n <= 1'b1;
			afi_rps_n <= 1'b1;
		end
		else
		begin
			afi_wps_n <= ~cmd.wr_beat;
			afi_rps_n <= ~cmd.rd_beat;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// address and write data
	////////////////////////////////////////////////////////////////////////////

	// address follows every beat of either kind and holds between beats
	always_ff @(posedge afi_clk)
	begin
		if (cmd.wr_beat || cmd.rd_beat)
			afi_addr <= cmd.addr;
	end

	// the parity encoder works on the request data in the same cycle,
	// so the encoded word lines up with the write select here
	always_ff @(posedge afi_clk)
	begin
		if (cmd.wr_beat)
			afi_wdata <= wdata_enc;
	end

endmodule

// File: source/memctl_parity.sv
// byte parity encoder for write data and parity checker for read data, purely combinational
`timescale 1ns/10ps

module memctl_parity
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES,
	parameter int DEC_W     = memctl_pkg::DATA_W,
	parameter int ENC_W     = memctl_pkg::ENC_W
)
(
	input  logic [DEC_W-1:0]     wdata_in,
	output logic [ENC_W-1:0]     wdata_out,
	input  logic                 rdata_valid,
	input  logic [ENC_W-1:0]     rdata_in,
	output logic [DEC_W-1:0]     rdata_out,
	output logic [NUM_BYTES-1:0] parity_error
);

	////////////////////////////////////////////////////////////////////////////
	// per-byte lanes
	////////////////////////////////////////////////////////////////////////////

	// lane i holds data byte i in its low eight bits and the parity bit on top
	for (genvar i = 0; i < NUM_BYTES; i++)
	begin : g_lane
		// the encoder adds a parity bit that makes the nine lane bits even
		assign wdata_out[i*9 +: 8] = wdata_in[i*8 +: 8];
		assign wdata_out[i*9 + 8]  = ^wdata_in[i*8 +: 8];

		// the decoder drops the parity bit on the way to the host
		assign rdata_out[i*8 +: 8] = rdata_in[i*9 +: 8];

		// an odd count of ones across the whole lane means some bit flipped
		// flags are forced low between returned beats
		assign parity_error[i] = rdata_valid & (^rdata_in[i*9 +: 9]);
	end

	////////////////////////////////////////////////////////////////////////////
	// width checks at elaboration
	////////////////////////////////////////////////////////////////////////////

	// the lane slicing above relies on exactly nine memory bits per byte
	if (ENC_W != NUM_BYTES * 9)
	begin : g_enc_width_chk
		$error("encoded width %0d is not nine bits per byte for %0d bytes", ENC_W, NUM_BYTES);
	end

	// and on exactly eight host bits per byte
	if (DEC_W != NUM_BYTES * 8)
	begin : g_dec_width_chk
		$error("decoded width %0d is not eight bits per byte for %0d bytes", DEC_W, NUM_BYTES);
	end

endmodule

// File: source/memctl_burst_ctl.sv
// burst control FSM, accepts host bursts and splits them into one memory request per beat
`timescale 1ns/10ps

module memctl_burst_ctl
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES
)
(
	input  logic                   afi_clk,
	input  logic                   rst_n,
	output logic                   avl_ready,
	input  logic                   avl_write_req,
	input  logic                   avl_read_req,
	input  memctl_pkg::addr_t      avl_addr,
	input  memctl_pkg::burst_t     avl_size,
	input  logic [NUM_BYTES*8-1:0] avl_wdata,
	memctl_cmd_if.ctl              cmd
);

	////////////////////////////////////////////////////////////////////////////
	// state and counters
	////////////////////////////////////////////////////////////////////////////

	memctl_pkg::burst_state_t state_q;
	memctl_pkg::burst_state_t state_d;

	// beats still to be issued after the current cycle
	memctl_pkg::burst_t beat_cnt_q;
	memctl_pkg::burst_t beat_cnt_d;

	// address of the next beat while a burst is running
	memctl_pkg::addr_t addr_q;
	memctl_pkg::addr_t addr_d;

	// a new burst is taken in this cycle
	logic accept_wr;
	logic accept_rd;

	// the host may only start a burst while the FSM sits in idle
	assign avl_ready = (state_q == memctl_pkg::BURST_IDLE);

	// a write wins if the host raises both strobes at once
	assign accept_wr = avl_ready & avl_write_req;
	assign accept_rd = avl_ready & avl_read_req & ~avl_write_req;

	////////////////////////////////////////////////////////////////////////////
	// next state and beat generation
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d    = state_q;
		beat_cnt_d = beat_cnt_q;
		addr_d     = addr_q;

		// write data always comes straight from the host, the strobe says if it counts
		cmd.wr_beat = 1'b0;
		cmd.rd_beat = 1'b0;
		cmd.addr    = addr_q;
		cmd.wdata   = avl_wdata;

		case (state_q)
			memctl_pkg::BURST_IDLE:
			begin
				// the first beat goes out in the accept cycle itself with the start address
				cmd.addr    = avl_addr;
				cmd.wr_beat = accept_wr;
				cmd.rd_beat = accept_rd;

				// single beat bursts never leave idle, so avl_ready stays high
				if ((accept_wr || accept_rd) && (avl_size > memctl_pkg::burst_t'(1)))
				begin
					beat_cnt_d = avl_size - memctl_pkg::burst_t'(1);
					addr_d     = avl_addr + memctl_pkg::addr_t'(1);
					if (accept_wr)
						state_d = memctl_pkg::BURST_WRITE;
					else
						state_d = memctl_pkg::BURST_READ;
				end
			end

			memctl_pkg::BURST_WRITE,
			memctl_pkg::BURST_READ:
			begin
				// the host streams write beats without gaps, so a beat leaves every cycle
				cmd.wr_beat = (state_q == memctl_pkg::BURST_WRITE);

				// read beats need no host activity after the request cycle
				cmd.rd_beat = (state_q == memctl_pkg::BURST_READ);

				beat_cnt_d = beat_cnt_q - memctl_pkg::burst_t'(1);
				addr_d     = addr_q + memctl_pkg::addr_t'(1);

				// last beat of the burst, ready rises again in the next cycle
				if (beat_cnt_q == memctl_pkg::burst_t'(1))
					state_d = memctl_pkg::BURST_IDLE;
			end

			default:
			begin
				state_d = memctl_pkg::BURST_IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge afi_clk)
	begin
		if (!rst_n)
		begin
			state_q    <= memctl_pkg::BURST_IDLE;
			beat_cnt_q <= '0;
		end
		else
		begin
			state_q    <= state_d;
			beat_cnt_q <= beat_cnt_d;
		end
	end

	// the address counter is loaded in the accept cycle of every multi-beat burst
	always_ff @(posedge afi_clk)
	begin
		addr_q <= addr_d;
	end

endmodule

// File: source/memctl_cmd_if.sv
// per-beat memory request bus between the burst control and the command issue stage
`timescale 1ns/10ps

interface memctl_cmd_if
#(
	parameter int NUM_BYTES = memctl_pkg::NUM_BYTES
);

	// one cycle strobe for a write beat, its data is valid in the same cycle
	logic wr_beat;

	// one cycle strobe for a read beat
	logic rd_beat;

	// word address of the current beat, meaningful only with one of the strobes
	memctl_pkg::addr_t addr;

	// write data before parity is added
	logic [NUM_BYTES*8-1:0] wdata;

	////////////////////////////////////////////////////////////////////////////
	// views of the bus
	////////////////////////////////////////////////////////////////////////////

	// the burst control produces every field of a request
	modport ctl
	(
		output wr_beat,
		output rd_beat,
		output addr,
		output wdata
	);

	// the issue stage consumes the request one cycle before the memory sees it
	modport issue
	(
		input wr_beat,
		input rd_beat,
		input addr,
		input wdata
	);

endinterface

// File: source/memctl_pkg.sv
// shared widths and types of the QDR SRAM controller, referenced by scoped name from every RTL block
package memctl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// data beat geometry
	////////////////////////////////////////////////////////////////////////////

	// default number of data bytes in one host beat
	localparam int NUM_BYTES = 4;

	// host side beat width, eight data bits per byte
	localparam int DATA_W = NUM_BYTES * 8;

	// memory side beat width, each byte travels with its parity bit in a nine bit lane
	localparam int ENC_W = NUM_BYTES * 9;

	////////////////////////////////////////////////////////////////////////////
	// address and burst fields
	////////////////////////////////////////////////////////////////////////////

	// one address counts one full memory word, not one byte
	localparam int ADDR_W = 10;

	// burst length field, legal bursts run from one to seven beats
	localparam int BURST_W = 3;

	// word address as seen on the host port and the memory port
	typedef logic [ADDR_W-1:0] addr_t;

	// number of beats in one host burst
	typedef logic [BURST_W-1:0] burst_t;

	////////////////////////////////////////////////////////////////////////////
	// burst control FSM
	////////////////////////////////////////////////////////////////////////////

	// idle accepts a new burst, the other two states issue the remaining beats
	typedef enum logic [1:0]
	{
		BURST_IDLE  = 2'd0,
		BURST_WRITE = 2'd1,
		BURST_READ  = 2'd2
	} burst_state_t;

endpackage
